/* phy_pkg.sv */
`default_nettype none

package phy_pkg;

    // ====================
    // widths
    // ====================
    localparam int BYTE_W    = 8;
    localparam int SYMBOL_W  = 10;
    localparam int FLIT_SYMS = 5;

    typedef logic [BYTE_W-1:0]              byte_t;
    typedef logic [SYMBOL_W-1:0]            symbol_t;
    typedef logic [FLIT_SYMS*BYTE_W-1:0]    flit_t;
    typedef logic [FLIT_SYMS*SYMBOL_W-1:0]  enc_flit_t;
    typedef logic [6:0]                     pkt_size_t;
    typedef logic [3:0]                     credit_t;

    // ====================
    // word classes
    // ====================
    // class given by the aligner with every word
    typedef enum logic [1:0] {
        COMMA_1_FLIT,
        COMMA_2_FLIT,
        COMMA_DATA
    } code_class_t;

    // decoded meaning of the last word
    typedef enum logic [2:0] {
        START_SEL,
        END_SEL,
        GRTCRED0_SEL,
        GRTCRED1_SEL,
        ACK_SEL,
        DATA_SEL
    } comma_sel_t;

    typedef enum logic [1:0] {
        LOOK_FOR_START,
        LOOK_FOR_DATA,
        LOOK_FOR_END
    } order_state_t;

    // ====================
    // comma codes
    // ====================
    // symbols are {abcdei, fghj} with bit a in the msb, all in the RD- form
    localparam symbol_t START_COMMA    = 10'b001111_1001;
    localparam symbol_t END_COMMA      = 10'b001111_1010;
    localparam symbol_t GRTCRED0_COMMA = 10'b001111_0101;
    localparam symbol_t GRTCRED1_COMMA = 10'b001111_0011;
    localparam symbol_t ACK_COMMA      = 10'b001111_0110;

    // ====================
    // buffering and credits
    // ====================
    localparam int RX_BUF_DEPTH = 8;
    localparam int RX_PTR_W     = $clog2(RX_BUF_DEPTH);

    localparam credit_t CREDIT_MAX = 4'd15;

endpackage

`default_nettype wire

/* dec_8b10b.sv */
`default_nettype none

module dec_8b10b (
    input  phy_pkg::symbol_t symbol,
    output phy_pkg::byte_t   data,
    output logic             is_k,
    output logic             code_err
);

    logic [5:0] six;
    logic [3:0] four;
    logic [3:0] k28_four;
    logic [4:0] lo5;
    logic [2:0] hi3;
    logic [2:0] k28_hi3;
    logic       six_err;
    logic       four_err;
    logic       k28_err;
    logic       alt7;
    logic       is_k28;

    assign six  = symbol[9:4];
    assign four = symbol[3:0];

    // 6b/5b table, both disparity forms share a line
    always_comb begin
        six_err = 1'b0;
        lo5     = 5'd0;
        case (six)
            6'b100111, 6'b011000: lo5 = 5'd0;
            6'b011101, 6'b100010: lo5 = 5'd1;
            6'b101101, 6'b010010: lo5 = 5'd2;
            6'b110001:            lo5 = 5'd3;
            6'b110101, 6'b001010: lo5 = 5'd4;
            6'b101001:            lo5 = 5'd5;
            6'b011001:            lo5 = 5'd6;
            6'b111000, 6'b000111: lo5 = 5'd7;
            6'b111001, 6'b000110: lo5 = 5'd8;
            6'b100101:            lo5 = 5'd9;
            6'b010101:            lo5 = 5'd10;
            6'b110100:            lo5 = 5'd11;
            6'b001101:            lo5 = 5'd12;
            6'b101100:            lo5 = 5'd13;
            6'b011100:            lo5 = 5'd14;
            6'b010111, 6'b101000: lo5 = 5'd15;
            6'b011011, 6'b100100: lo5 = 5'd16;
            6'b100011:            lo5 = 5'd17;
            6'b010011:            lo5 = 5'd18;
            6'b110010:            lo5 = 5'd19;
            6'b001011:            lo5 = 5'd20;
            6'b101010:            lo5 = 5'd21;
            6'b011010:            lo5 = 5'd22;
            6'b111010, 6'b000101: lo5 = 5'd23;
            6'b110011, 6'b001100: lo5 = 5'd24;
            6'b100110:            lo5 = 5'd25;
            6'b010110:            lo5 = 5'd26;
            6'b110110, 6'b001001: lo5 = 5'd27;
            6'b001110, 6'b001111, 6'b110000: lo5 = 5'd28;
            6'b101110, 6'b010001: lo5 = 5'd29;
            6'b011110, 6'b100001: lo5 = 5'd30;
            6'b101011, 6'b010100: lo5 = 5'd31;
            default:              six_err = 1'b1;
        endcase
    end

    // 4b/3b table for data characters and the K.x.7 group
    always_comb begin
        four_err = 1'b0;
        alt7     = 1'b0;
        hi3      = 3'd0;
        case (four)
            4'b1011, 4'b0100: hi3 = 3'd0;
            4'b1001:          hi3 = 3'd1;
            4'b0101:          hi3 = 3'd2;
            4'b1100, 4'b0011: hi3 = 3'd3;
            4'b1101, 4'b0010: hi3 = 3'd4;
            4'b1010:          hi3 = 3'd5;
            4'b0110:          hi3 = 3'd6;
            4'b1110, 4'b0001: hi3 = 3'd7;
            4'b0111, 4'b1000: begin
                hi3  = 3'd7;
                alt7 = 1'b1;
            end
            default:          four_err = 1'b1;
        endcase
    end

    // K28 sub-blocks follow their own 4b mapping, the RD+ form is the inverse
    assign is_k28   = (six == 6'b001111) || (six == 6'b110000);
    assign k28_four = (six == 6'b110000) ? ~four : four;

    always_comb begin
        k28_err = 1'b0;
        k28_hi3 = 3'd0;
        case (k28_four)
            4'b0100: k28_hi3 = 3'd0;
            4'b1001: k28_hi3 = 3'd1;
            4'b0101: k28_hi3 = 3'd2;
            4'b0011: k28_hi3 = 3'd3;
            4'b0010: k28_hi3 = 3'd4;
            4'b1010: k28_hi3 = 3'd5;
            4'b0110: k28_hi3 = 3'd6;
            4'b1000: k28_hi3 = 3'd7;
            default: k28_err = 1'b1;
        endcase
    end

    // K23.7, K27.7, K29.7 and K30.7 use the alternate x.7 sub-block
    assign is_k = is_k28 ||
                  (alt7 && (lo5 == 5'd23 || lo5 == 5'd27 || lo5 == 5'd29 || lo5 == 5'd30));

    assign data     = {(is_k28 ? k28_hi3 : hi3), lo5};
    assign code_err = six_err || (is_k28 ? k28_err : four_err);

endmodule

`default_nettype wire

/* flit_decoder.sv */
`default_nettype none

module flit_decoder (
    input  logic                 CLK,
    input  logic                 nRST,
    input  phy_pkg::enc_flit_t   enc_flit,
    input  logic                 done,
    input  phy_pkg::code_class_t code_class,
    output logic                 done_out,
    output phy_pkg::comma_sel_t  comma_sel,
    output logic                 err_out,
    output phy_pkg::pkt_size_t   curr_packet_size,
    output logic                 ack_vc,
    output logic [1:0]           ack_id,
    output logic [4:0]           ack_req,
    output phy_pkg::flit_t       decoded_flit,
    output logic                 data_push,
    output logic                 grant_vc0,
    output logic                 grant_vc1
);
    import phy_pkg::*;

    flit_t          dec_flit;
    logic [4:0]     sym_k;
    logic [4:0]     sym_err;
    symbol_t        sym0;
    symbol_t        sym1;
    comma_sel_t     n_comma_sel;
    order_state_t   state;
    order_state_t   n_state;
    pkt_size_t      n_packet_size;
    logic           comma_err;
    logic           order_err;
    logic           word_err;
    logic           is_data;
    logic           is_comma;
    logic           is_start;
    logic           is_end;
    logic           is_ack;

    genvar i;
    generate
        for (i = 0; i < FLIT_SYMS; i = i + 1) begin : g_sym
            dec_8b10b u_dec (
                .symbol   (enc_flit[i*SYMBOL_W +: SYMBOL_W]),
                .data     (dec_flit[i*BYTE_W +: BYTE_W]),
                .is_k     (sym_k[i]),
                .code_err (sym_err[i])
            );
        end
    endgenerate

    assign sym0     = enc_flit[SYMBOL_W-1:0];
    assign sym1     = enc_flit[2*SYMBOL_W-1:SYMBOL_W];
    assign is_data  = done && (code_class == COMMA_DATA);
    assign is_comma = done && (code_class != COMMA_DATA);
    assign is_start = done && (code_class == COMMA_1_FLIT) && (sym0 == START_COMMA);
    assign is_end   = done && (code_class == COMMA_1_FLIT) && (sym0 == END_COMMA);
    assign is_ack   = done && (code_class == COMMA_2_FLIT) && (sym1 == ACK_COMMA);

    // ====================
    // comma classification
    // ====================
    always_comb begin
        n_comma_sel = comma_sel;
        comma_err   = 1'b0;
        if (done) begin
            case (code_class)
                COMMA_1_FLIT: begin
                    case (sym0)
                        START_COMMA:    n_comma_sel = START_SEL;
                        END_COMMA:      n_comma_sel = END_SEL;
                        GRTCRED0_COMMA: n_comma_sel = GRTCRED0_SEL;
                        GRTCRED1_COMMA: n_comma_sel = GRTCRED1_SEL;
                        default:        comma_err   = 1'b1;
                    endcase
                end
                COMMA_2_FLIT: begin
                    if (sym1 == ACK_COMMA) begin
                        n_comma_sel = ACK_SEL;
                    end else begin
                        comma_err = 1'b1;
                    end
                end
                COMMA_DATA: n_comma_sel = DATA_SEL;
                default:    comma_err   = 1'b1;
            endcase
        end
    end

    // ====================
    // packet order
    // ====================
    always_comb begin
        n_state   = state;
        order_err = 1'b0;
        case (state)
            LOOK_FOR_START: begin
                if (is_start) begin
                    n_state = LOOK_FOR_DATA;
                end else if (is_data) begin
                    order_err = 1'b1;
                end
            end
            LOOK_FOR_DATA: begin
                if (is_data) begin
                    n_state = LOOK_FOR_END;
                end else if (is_comma) begin
                    order_err = 1'b1;
                end
            end
            LOOK_FOR_END: begin
                if (is_end) begin
                    n_state = LOOK_FOR_START;
                end else if (is_comma) begin
                    order_err = 1'b1;
                    // a repeated start opens a fresh packet
                    if (is_start) begin
                        n_state = LOOK_FOR_DATA;
                    end
                end
            end
            default: n_state = LOOK_FOR_START;
        endcase
    end

    // first data flit announces the length in byte 0, later flits count it down
    always_comb begin
        n_packet_size = curr_packet_size;
        if (is_data) begin
            if (state == LOOK_FOR_DATA) begin
                n_packet_size = (dec_flit[6:0] == 7'd0) ? 7'd0 : dec_flit[6:0] - 7'd1;
            end else if (curr_packet_size != 7'd0) begin
                n_packet_size = curr_packet_size - 7'd1;
            end
        end else if (is_comma) begin
            n_packet_size = '0;
        end
    end

    assign word_err = done && ((|sym_err) || (is_data && (|sym_k)) || comma_err || order_err);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            done_out         <= 1'b0;
            err_out          <= 1'b0;
            comma_sel        <= START_SEL;
            curr_packet_size <= '0;
            state            <= LOOK_FOR_START;
            data_push        <= 1'b0;
            grant_vc0        <= 1'b0;
            grant_vc1        <= 1'b0;
        end else begin
            done_out         <= done;
            err_out          <= word_err;
            comma_sel        <= n_comma_sel;
            curr_packet_size <= n_packet_size;
            state            <= n_state;
            data_push        <= is_data && !word_err;
            // a grant inside a damaged or misplaced word is not trusted
            grant_vc0        <= !word_err && (n_comma_sel == GRTCRED0_SEL) && is_comma;
            grant_vc1        <= !word_err && (n_comma_sel == GRTCRED1_SEL) && is_comma;
        end
    end

    always_ff @(posedge CLK) begin
        if (is_data) begin
            decoded_flit <= dec_flit;
        end
        if (is_ack) begin
            ack_vc  <= dec_flit[7];
            ack_id  <= dec_flit[6:5];
            ack_req <= dec_flit[4:0];
        end
    end

endmodule

`default_nettype wire

/* tx_credit_counter.sv */
`default_nettype none

module tx_credit_counter (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             grant_vc0,
    input  logic             grant_vc1,
    input  logic             tx_consume_vc0,
    input  logic             tx_consume_vc1,
    output phy_pkg::credit_t credits_vc0,
    output phy_pkg::credit_t credits_vc1
);
    import phy_pkg::*;

    // grant and consume together cancel out
    function automatic credit_t next_credit(credit_t cnt, logic up, logic down);
        credit_t nxt;
        nxt = cnt;
        if (up && !down && cnt != CREDIT_MAX) begin
            nxt = cnt + 4'd1;
        end else if (down && !up && cnt != 4'd0) begin
            nxt = cnt - 4'd1;
        end
        return nxt;
    endfunction

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            credits_vc0 <= '0;
            credits_vc1 <= '0;
        end else begin
            credits_vc0 <= next_credit(credits_vc0, grant_vc0, tx_consume_vc0);
            credits_vc1 <= next_credit(credits_vc1, grant_vc1, tx_consume_vc1);
        end
    end

endmodule

`default_nettype wire

/* rx_flit_buffer.sv */
`default_nettype none

module rx_flit_buffer (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           push,
    input  phy_pkg::flit_t flit_in,
    input  logic           pop,
    output phy_pkg::flit_t rx_flit,
    output logic           rx_valid,
    output logic           credit_return,
    output logic           overflow
);
    import phy_pkg::*;

    flit_t               mem [RX_BUF_DEPTH];
    logic [RX_PTR_W-1:0] wr_ptr;
    logic [RX_PTR_W-1:0] rd_ptr;
    logic [RX_PTR_W:0]   count;
    logic                full;
    logic                push_ok;
    logic                pop_ok;

    assign full     = (count == (RX_PTR_W+1)'(RX_BUF_DEPTH));
    assign rx_valid = (count != '0);
    assign rx_flit  = mem[rd_ptr];
    assign push_ok  = push && !full;
    assign pop_ok   = pop && rx_valid;

    always_ff @(posedge CLK) begin
        if (push_ok) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
            // each freed slot goes back to the partner as one credit
            credit_return <= pop_ok;
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* phy_rx.sv */
`default_nettype none

module phy_rx (
    input  logic                 CLK,
    input  logic                 nRST,
    input  phy_pkg::enc_flit_t   enc_flit,
    input  logic                 done,
    input  phy_pkg::code_class_t code_class,
    input  logic                 pop,
    input  logic                 tx_consume_vc0,
    input  logic                 tx_consume_vc1,
    output logic                 done_out,
    output phy_pkg::comma_sel_t  comma_sel,
    output logic                 err_out,
    output phy_pkg::pkt_size_t   curr_packet_size,
    output logic                 ack_vc,
    output logic [1:0]           ack_id,
    output logic [4:0]           ack_req,
    output phy_pkg::flit_t       rx_flit,
    output logic                 rx_valid,
    output logic                 credit_return,
    output logic                 overflow,
    output phy_pkg::credit_t     credits_vc0,
    output phy_pkg::credit_t     credits_vc1
);
    import phy_pkg::*;

    flit_t decoded_flit;
    logic  data_push;
    logic  grant_vc0;
    logic  grant_vc1;

    flit_decoder u_flit_decoder (
        .CLK              (CLK),
        .nRST             (nRST),
        .enc_flit         (enc_flit),
        .done             (done),
        .code_class       (code_class),
        .done_out         (done_out),
        .comma_sel        (comma_sel),
        .err_out          (err_out),
        .curr_packet_size (curr_packet_size),
        .ack_vc           (ack_vc),
        .ack_id           (ack_id),
        .ack_req          (ack_req),
        .decoded_flit     (decoded_flit),
        .data_push        (data_push),
        .grant_vc0        (grant_vc0),
        .grant_vc1        (grant_vc1)
    );

    rx_flit_buffer u_rx_flit_buffer (
        .CLK           (CLK),
        .nRST          (nRST),
        .push          (data_push),
        .flit_in       (decoded_flit),
        .pop           (pop),
        .rx_flit       (rx_flit),
        .rx_valid      (rx_valid),
        .credit_return (credit_return),
        .overflow      (overflow)
    );

    tx_credit_counter u_tx_credit_counter (
        .CLK            (CLK),
        .nRST           (nRST),
        .grant_vc0      (grant_vc0),
        .grant_vc1      (grant_vc1),
        .tx_consume_vc0 (tx_consume_vc0),
        .tx_consume_vc1 (tx_consume_vc1),
        .credits_vc0    (credits_vc0),
        .credits_vc1    (credits_vc1)
    );

endmodule

`default_nettype wire

/* phy_rx_properties.sv */
`default_nettype none

module phy_rx_properties (
    input logic             CLK,
    input logic             nRST,
    input logic             pop,
    input logic             rx_valid,
    input logic             credit_return,
    input phy_pkg::credit_t credits_vc0,
    input phy_pkg::credit_t credits_vc1
);
    timeunit 1ns;
    timeprecision 100ps;

    // the head entry stays until the consumer takes it
    assert property (@(posedge CLK) disable iff (!nRST) $fell(rx_valid) |-> $past(pop))
        else $error("rx_valid dropped without a pop");

    assert property (@(posedge CLK) disable iff (!nRST) (pop && rx_valid) |=> credit_return)
        else $error("credit_return missing after a valid pop");

    assert property (@(posedge CLK) disable iff (!nRST) credit_return |-> $past(pop && rx_valid))
        else $error("credit_return without a prior pop");

    // each count moves by at most one step and never wraps around
    assert property (@(posedge CLK) disable iff (!nRST)
                     ((int'(credits_vc0) - int'($past(credits_vc0))) inside {-1, 0, 1}) &&
                     ((int'(credits_vc1) - int'($past(credits_vc1))) inside {-1, 0, 1}))
        else $error("credit count out of range");

endmodule

bind phy_rx phy_rx_properties phy_rx_properties_i (.*);

`default_nettype wire

/* phy_rx_tb.sv */
`default_nettype none

module phy_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import phy_pkg::*;

    // worst case word count of the sequence below
    localparam int MAX_WORDS    = 20 * 7 + 5 + 11 + 60 + 8 + 11;
    localparam int CYC_PER_WORD = 40;

    typedef enum int {W_START, W_END, W_GRT0, W_GRT1, W_ACK, W_DATA, W_BADK} word_kind_t;

    typedef struct packed {
        comma_sel_t sel;
        logic       err;
        pkt_size_t  size;
        logic       ack;
        byte_t      ackb;
    } exp_t;

    // RD- forms, 5b/6b indexed by EDCBA and 3b/4b by HGF
    localparam logic [5:0] ENC6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    localparam logic [3:0] ENC4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };

    logic                CLK;
    logic                nRST;
    enc_flit_t           enc_flit;
    logic                done;
    code_class_t         code_class;
    logic                pop;
    logic                tx_consume_vc0;
    logic                tx_consume_vc1;
    logic                done_out;
    comma_sel_t          comma_sel;
    logic                err_out;
    pkt_size_t           curr_packet_size;
    logic                ack_vc;
    logic [1:0]          ack_id;
    logic [4:0]          ack_req;
    flit_t               rx_flit;
    logic                rx_valid;
    logic                credit_return;
    logic                overflow;
    credit_t             credits_vc0;
    credit_t             credits_vc1;

    // reference model state
    order_state_t ref_state;
    pkt_size_t    ref_size;
    comma_sel_t   ref_sel;
    credit_t      cred0;
    credit_t      cred1;
    logic         exp_ovf;
    exp_t         exp_q [$];
    flit_t        flit_q [$];

    logic pop_en;
    int   pops;
    int   returns;
    int   val_errs;
    int   other_errs;

    phy_rx phy_rx_i (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // ====================
    // encoder and reference
    // ====================
    function automatic symbol_t encode_byte(byte_t b);
        return {ENC6[b[4:0]], ENC4[b[7:5]]};
    endfunction

    function automatic enc_flit_t encode_flit(flit_t f);
        enc_flit_t e;
        for (int i = 0; i < FLIT_SYMS; i++) begin
            e[i*SYMBOL_W +: SYMBOL_W] = encode_byte(f[i*BYTE_W +: BYTE_W]);
        end
        return e;
    endfunction

    function automatic flit_t rand_flit();
        return flit_t'({$urandom(), $urandom()});
    endfunction

    // expected outputs of one word, the model state moves along with it
    function automatic void predict(word_kind_t kind, logic bad, flit_t f);
        exp_t e;
        logic is_data;
        is_data = (kind == W_DATA);
        e = '0;
        e.err = bad || (kind == W_BADK);
        case (kind)
            W_START: ref_sel = START_SEL;
            W_END:   ref_sel = END_SEL;
            W_GRT0:  ref_sel = GRTCRED0_SEL;
            W_GRT1:  ref_sel = GRTCRED1_SEL;
            W_ACK:   ref_sel = ACK_SEL;
            W_DATA:  ref_sel = DATA_SEL;
            default: ref_sel = ref_sel;
        endcase
        if (is_data) begin
            if (ref_state == LOOK_FOR_DATA) begin
                ref_size = (f[6:0] == 7'd0) ? 7'd0 : f[6:0] - 7'd1;
            end else if (ref_size != 7'd0) begin
                ref_size = ref_size - 7'd1;
            end
        end else begin
            ref_size = '0;
        end
        case (ref_state)
            LOOK_FOR_START: begin
                if (kind == W_START) begin
                    ref_state = LOOK_FOR_DATA;
                end else if (is_data) begin
                    e.err = 1'b1;
                end
            end
            LOOK_FOR_DATA: begin
                if (is_data) begin
                    ref_state = LOOK_FOR_END;
                end else begin
                    e.err = 1'b1;
                end
            end
            default: begin
                if (kind == W_END) begin
                    ref_state = LOOK_FOR_START;
                end else if (!is_data) begin
                    e.err = 1'b1;
                    if (kind == W_START) begin
                        ref_state = LOOK_FOR_DATA;
                    end
                end
            end
        endcase
        if (!e.err && kind == W_GRT0 && cred0 != CREDIT_MAX) begin
            cred0 = cred0 + 4'd1;
        end
        if (!e.err && kind == W_GRT1 && cred1 != CREDIT_MAX) begin
            cred1 = cred1 + 4'd1;
        end
        if (is_data && !e.err) begin
            if (flit_q.size() < RX_BUF_DEPTH) begin
                flit_q.push_back(f);
            end else begin
                exp_ovf = 1'b1;
            end
        end
        e.sel  = ref_sel;
        e.size = ref_size;
        e.ack  = (kind == W_ACK);
        e.ackb = f[7:0];
        exp_q.push_back(e);
    endfunction

    // ====================
    // stimulus tasks
    // ====================
    // bad 1 breaks a symbol, bad 2 puts a K character into the data
    task automatic send_word(word_kind_t kind, int bad, flit_t f);
        enc_flit_t   e;
        code_class_t c;
        e = encode_flit(f);
        c = COMMA_1_FLIT;
        case (kind)
            W_START: e[9:0] = START_COMMA;
            W_END:   e[9:0] = END_COMMA;
            W_GRT0:  e[9:0] = GRTCRED0_COMMA;
            W_GRT1:  e[9:0] = GRTCRED1_COMMA;
            W_BADK:  e[9:0] = 10'b001111_1000;
            W_ACK: begin
                e[19:10] = ACK_COMMA;
                c = COMMA_2_FLIT;
            end
            default: begin
                c = COMMA_DATA;
                if (bad == 1) begin
                    e[39:30] = 10'h3ff;
                end else if (bad == 2) begin
                    e[29:20] = END_COMMA;
                end
            end
        endcase
        @(negedge CLK);
        predict(kind, bad != 0, f);
        enc_flit   = e;
        code_class = c;
        done       = 1'b1;
        @(negedge CLK);
        done = 1'b0;
        repeat (3) @(negedge CLK);
    endtask

    task automatic send_packet(int n);
        send_word(W_START, 0, rand_flit());
        repeat (n) send_word(W_DATA, 0, rand_flit());
        send_word(W_END, 0, rand_flit());
    endtask

    task automatic consume(int vc);
        @(negedge CLK);
        tx_consume_vc0 = (vc == 0);
        tx_consume_vc1 = (vc == 1);
        if (vc == 0 && cred0 != 4'd0) begin
            cred0 = cred0 - 4'd1;
        end
        if (vc == 1 && cred1 != 4'd0) begin
            cred1 = cred1 - 4'd1;
        end
        @(negedge CLK);
        tx_consume_vc0 = 1'b0;
        tx_consume_vc1 = 1'b0;
    endtask

    task automatic check_credits();
        assert (credits_vc0 == cred0) else begin
            $display("** Error @%0t: credits_vc0 got %0d expected %0d", $time, credits_vc0, cred0);
            val_errs++;
        end
        assert (credits_vc1 == cred1) else begin
            $display("** Error @%0t: credits_vc1 got %0d expected %0d", $time, credits_vc1, cred1);
            val_errs++;
        end
    endtask

    task automatic drain();
        pop_en = 1'b1;
        while (flit_q.size() != 0) @(negedge CLK);
        repeat (3) @(negedge CLK);
    endtask

    // ====================
    // compare process
    // ====================
    always @(negedge CLK) begin
        exp_t e;
        if (done_out) begin
            if (exp_q.size() == 0) begin
                $display("done_out pulsed at %0t with no word outstanding", $time);
                other_errs++;
            end else begin
                e = exp_q.pop_front();
                assert (comma_sel == e.sel) else begin
                    $display("** Error @%0t: comma_sel got %s expected %s",
                             $time, comma_sel.name(), e.sel.name());
                    val_errs++;
                end
                assert (err_out == e.err) else begin
                    $display("** Error @%0t: err_out got %b expected %b", $time, err_out, e.err);
                    val_errs++;
                end
                assert (curr_packet_size == e.size) else begin
                    $display("** Error @%0t: curr_packet_size got %0d expected %0d",
                             $time, curr_packet_size, e.size);
                    val_errs++;
                end
                if (e.ack && !e.err) begin
                    assert ({ack_vc, ack_id, ack_req} == e.ackb) else begin
                        $display("** Error @%0t: ack_vc/ack_id/ack_req got %h expected %h",
                                 $time, {ack_vc, ack_id, ack_req}, e.ackb);
                        val_errs++;
                    end
                end
            end
        end
        if (credit_return) begin
            returns++;
        end
        pop = 1'b0;
        if (pop_en && rx_valid && ($urandom % 2 == 0)) begin
            if (flit_q.size() == 0) begin
                $display("rx_valid high at %0t with no flit expected", $time);
                other_errs++;
            end else begin
                assert (rx_flit == flit_q[0]) else begin
                    $display("** Error @%0t: rx_flit got %h expected %h",
                             $time, rx_flit, flit_q[0]);
                    val_errs++;
                end
                void'(flit_q.pop_front());
                pop = 1'b1;
                pops++;
            end
        end
    end

    initial begin
        repeat (MAX_WORDS * CYC_PER_WORD + 200) @(posedge CLK);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    // ====================
    // test sequence
    // ====================
    initial begin
        void'($urandom(32'hb1cb));
        nRST = 1'b0;
        enc_flit = '0;
        done = 1'b0;
        code_class = COMMA_1_FLIT;
        pop = 1'b0;
        tx_consume_vc0 = 1'b0;
        tx_consume_vc1 = 1'b0;
        ref_state = LOOK_FOR_START;
        ref_size = '0;
        ref_sel = START_SEL;
        cred0 = '0;
        cred1 = '0;
        exp_ovf = 1'b0;
        pop_en = 1'b1;
        pops = 0;
        returns = 0;
        val_errs = 0;
        other_errs = 0;
        repeat (10) @(negedge CLK);
        nRST = 1'b1;

        // legal packets with the length countdown
        repeat (20) send_packet(1 + int'($urandom % 5));
        drain();

        // damaged words, the unknown comma arrives outside a packet
        send_word(W_START, 0, rand_flit());
        send_word(W_DATA, 1, rand_flit());
        send_word(W_DATA, 2, rand_flit());
        send_word(W_END, 0, rand_flit());
        send_word(W_BADK, 0, rand_flit());

        // order violations
        send_word(W_DATA, 0, rand_flit());
        send_word(W_START, 0, rand_flit());
        send_word(W_DATA, 0, rand_flit());
        send_word(W_GRT0, 0, rand_flit());
        send_word(W_START, 0, rand_flit());
        send_word(W_DATA, 0, rand_flit());
        send_word(W_END, 0, rand_flit());
        send_word(W_START, 0, rand_flit());
        send_word(W_END, 0, rand_flit());
        send_word(W_DATA, 0, rand_flit());
        send_word(W_END, 0, rand_flit());
        drain();

        // grants weighted so that the counts reach saturation
        repeat (60) begin
            case ($urandom % 6)
                0, 1:    send_word(W_GRT0, 0, rand_flit());
                2, 3:    send_word(W_GRT1, 0, rand_flit());
                4:       consume(0);
                default: consume(1);
            endcase
            check_credits();
        end
        repeat (8) send_word(W_ACK, 0, rand_flit());

        assert (overflow == 1'b0) else begin
            $display("** Error @%0t: overflow got %b expected %b", $time, overflow, 1'b0);
            val_errs++;
        end

        // nine flits into an eight entry buffer with the consumer stalled
        pop_en = 1'b0;
        send_packet(9);
        assert (overflow == exp_ovf && exp_ovf) else begin
            $display("** Error @%0t: overflow got %b expected %b", $time, overflow, 1'b1);
            val_errs++;
        end
        drain();

        if (exp_q.size() != 0) begin
            $display("%0d words never produced done_out", exp_q.size());
            other_errs++;
        end
        if (returns != pops) begin
            $display("credit_return pulsed %0d times for %0d pops", returns, pops);
            other_errs++;
        end
        $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
phy_pkg.sv
dec_8b10b.sv
flit_decoder.sv
tx_credit_counter.sv
rx_flit_buffer.sv
phy_rx.sv
phy_rx_properties.sv
phy_rx_tb.sv

/* Makefile */
SRCS = phy_pkg.sv dec_8b10b.sv flit_decoder.sv tx_credit_counter.sv \
       rx_flit_buffer.sv phy_rx.sv phy_rx_properties.sv phy_rx_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vphy_rx_tb: $(SRCS) verilog.f
	verilator --binary --timing --assert --top-module phy_rx_tb -f verilog.f

sim.log: obj_dir/Vphy_rx_tb
	./obj_dir/Vphy_rx_tb > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
